/* src/usb_txn_cfg.svh */
`ifndef USB_TXN_CFG_SVH
`define USB_TXN_CFG_SVH

// Endpoint numbers of the two bulk endpoints
`define USB_EP_OUT_NUM 4'd1
`define USB_EP_IN_NUM 4'd2

// Bus turnaround limit in clocks, for the host handshake after DATAx
`define USB_TA_CYCLES 7'd101

// Limit for the local endpoint or encoder to start responding
`define USB_EP_CYCLES 5'd23

`endif

/* src/usb_txn_pkg.sv */
package usb_txn_pkg;

  // Standard USB 2.0 PID codes, lower nibble only
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_PING  = 4'b0100
  } usb_pid_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RECV,
    ST_RESP,
    ST_DROP,
    ST_SEND,
    ST_WAIT
  } txn_state_e;

  // DATAx view, where the top bit is the sequence bit
  typedef struct packed {
    logic       seq;
    logic [2:0] kind;
  } rx_data_t;

  typedef union packed {
    usb_pid_e pid;
    rx_data_t data;
  } rx_pid_u;

endpackage

/* src/token_select.sv */
`include "usb_txn_cfg.svh"

module token_select (
  input  logic       clock,
  input  logic       reset,
  input  logic       set_conf_i,
  input  logic       clr_conf_i,
  input  logic [6:0] usb_addr_i,
  input  logic       tok_recv_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  input  logic       ep1_rx_rdy_i,
  input  logic       ep2_tx_rdy_i,
  input  logic       txn_end_i,
  output logic       tok_hit_o,
  output logic       ep_known_o,
  output logic       out_rdy_o,
  output logic       in_rdy_o,
  output logic       ep0_sel_o,
  output logic       epo_sel_o,
  output logic       epi_sel_o,
  output logic [1:0] ep_index_o
);

  logic ep1_en;
  logic ep2_en;
  logic is_ep0;
  logic is_epo;
  logic is_epi;

  assign tok_hit_o = tok_recv_i && (tok_addr_i == usb_addr_i);

  // Bulk endpoints only count once the device is configured
  assign is_ep0 = tok_endp_i == 4'd0;
  assign is_epo = ep1_en && (tok_endp_i == `USB_EP_OUT_NUM);
  assign is_epi = ep2_en && (tok_endp_i == `USB_EP_IN_NUM);

  assign ep_known_o = is_ep0 || is_epo || is_epi;

  // EP0 control transfers are always accepted
  assign out_rdy_o = is_ep0 || (is_epo && ep1_rx_rdy_i);
  assign in_rdy_o  = is_ep0 || (is_epi && ep2_tx_rdy_i);

  always_ff @(posedge clock) begin
    if (reset || clr_conf_i) begin
      ep1_en <= 1'b0;
      ep2_en <= 1'b0;
    end else if (set_conf_i) begin
      ep1_en <= 1'b1;
      ep2_en <= 1'b1;
    end
  end

  // Selects hold from the token until the transaction ends
  always_ff @(posedge clock) begin
    if (reset || clr_conf_i || txn_end_i) begin
      ep0_sel_o <= 1'b0;
      epo_sel_o <= 1'b0;
      epi_sel_o <= 1'b0;
    end else if (tok_hit_o) begin
      ep0_sel_o <= is_ep0;
      epo_sel_o <= is_epo;
      epi_sel_o <= is_epi;
    end
  end

  always_comb begin
    if (ep0_sel_o) begin
      ep_index_o = 2'd0;
    end else if (epo_sel_o) begin
      ep_index_o = 2'd1;
    end else if (epi_sel_o) begin
      ep_index_o = 2'd2;
    end else begin
      ep_index_o = 2'd3;
    end
  end

  sel_onehot_a: assert property (@(posedge clock) disable iff (reset)
    $onehot0({ep0_sel_o, epo_sel_o, epi_sel_o}));

endmodule

/* src/txn_fsm.sv */
module txn_fsm (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    tok_hit_i,
  input  logic                    ep_known_i,
  input  logic                    out_rdy_i,
  input  logic                    in_rdy_i,
  input  logic                    ep0_sel_i,
  input  logic                    epo_sel_i,
  input  logic                    epi_sel_i,
  input  logic                    ep0_parity_i,
  input  logic                    ep1_parity_i,
  input  logic                    ep2_parity_i,
  input  logic [3:0]              usb_pid_i,
  input  logic                    dec_actv_i,
  input  logic                    usb_recv_i,
  input  logic                    eop_recv_i,
  input  logic                    crc_error_i,
  input  logic                    hsk_recv_i,
  input  logic                    hsk_sent_i,
  input  logic                    usb_sent_i,
  input  logic                    timeout_i,
  output usb_txn_pkg::txn_state_e state_o,
  output usb_txn_pkg::usb_pid_e   resp_pid_o,
  output logic                    ta_start_o,
  output logic                    ep_start_o,
  output logic                    txn_end_o,
  output logic                    seq_o
);

  usb_txn_pkg::rx_pid_u rx_pid;
  logic                 par_w;
  logic                 par_q;
  logic                 ctrl_ep;

  assign rx_pid = usb_pid_i;

  // Only the control endpoint is ready in both directions
  assign ctrl_ep = out_rdy_i && in_rdy_i;

  // DATAx sequence check against the endpoint that takes the data
  assign par_w = (ep0_sel_i && (ep0_parity_i == rx_pid.data.seq)) ||
                 (epo_sel_i && (ep1_parity_i == rx_pid.data.seq));

  always_ff @(posedge clock) begin
    if (dec_actv_i) begin
      par_q <= par_w;
    end
  end

  // Sequence bit of the DATAx packet sent for an IN
  assign seq_o = (ep0_sel_i && ep0_parity_i) || (epi_sel_i && ep2_parity_i);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_o    <= usb_txn_pkg::ST_IDLE;
      resp_pid_o <= usb_txn_pkg::PID_NAK;
      ta_start_o <= 1'b0;
      ep_start_o <= 1'b0;
      txn_end_o  <= 1'b0;
    end else begin
      ta_start_o <= 1'b0;
      ep_start_o <= 1'b0;
      txn_end_o  <= 1'b0;
      case (state_o)
        usb_txn_pkg::ST_IDLE: begin
          if (tok_hit_i) begin
            case (rx_pid.pid)
              usb_txn_pkg::PID_SETUP: begin
                if (ctrl_ep) begin
                  state_o    <= usb_txn_pkg::ST_RECV;
                  ep_start_o <= 1'b1;
                end else begin
                  // Unsupported, so let the host time out
                  state_o    <= usb_txn_pkg::ST_WAIT;
                  ta_start_o <= 1'b1;
                end
              end
              usb_txn_pkg::PID_OUT: begin
                if (out_rdy_i) begin
                  state_o    <= usb_txn_pkg::ST_RECV;
                  ep_start_o <= 1'b1;
                end else if (ep_known_i) begin
                  // No room, discard the packet and NAK it
                  state_o <= usb_txn_pkg::ST_DROP;
                end else begin
                  state_o    <= usb_txn_pkg::ST_WAIT;
                  ta_start_o <= 1'b1;
                end
              end
              usb_txn_pkg::PID_IN: begin
                if (in_rdy_i) begin
                  state_o    <= usb_txn_pkg::ST_SEND;
                  ep_start_o <= 1'b1;
                end else if (ep_known_i) begin
                  state_o    <= usb_txn_pkg::ST_RESP;
                  resp_pid_o <= usb_txn_pkg::PID_NAK;
                  ep_start_o <= 1'b1;
                end else begin
                  state_o    <= usb_txn_pkg::ST_WAIT;
                  ta_start_o <= 1'b1;
                end
              end
              usb_txn_pkg::PID_PING: begin
                state_o    <= usb_txn_pkg::ST_RESP;
                resp_pid_o <= out_rdy_i ? usb_txn_pkg::PID_ACK : usb_txn_pkg::PID_NAK;
                ep_start_o <= 1'b1;
              end
              default: begin
                // Not a token we handle, release the selects
                txn_end_o <= 1'b1;
              end
            endcase
          end
        end
        usb_txn_pkg::ST_RECV: begin
          if (usb_recv_i) begin
            if (par_q) begin
              state_o    <= usb_txn_pkg::ST_RESP;
              resp_pid_o <= usb_txn_pkg::PID_ACK;
              ep_start_o <= 1'b1;
            end else begin
              state_o   <= usb_txn_pkg::ST_IDLE;
              txn_end_o <= 1'b1;
            end
          end else if (crc_error_i || timeout_i) begin
            // Host retries a corrupt or missing DATAx
            state_o   <= usb_txn_pkg::ST_IDLE;
            txn_end_o <= 1'b1;
          end
        end
        usb_txn_pkg::ST_DROP: begin
          if (eop_recv_i) begin
            state_o    <= usb_txn_pkg::ST_RESP;
            resp_pid_o <= usb_txn_pkg::PID_NAK;
            ep_start_o <= 1'b1;
          end else if (timeout_i) begin
            state_o   <= usb_txn_pkg::ST_IDLE;
            txn_end_o <= 1'b1;
          end
        end
        usb_txn_pkg::ST_SEND: begin
          if (usb_sent_i) begin
            // Now the host owes us a handshake
            state_o    <= usb_txn_pkg::ST_WAIT;
            ta_start_o <= 1'b1;
          end else if (timeout_i) begin
            state_o   <= usb_txn_pkg::ST_IDLE;
            txn_end_o <= 1'b1;
          end
        end
        usb_txn_pkg::ST_RESP: begin
          if (hsk_sent_i || timeout_i) begin
            state_o   <= usb_txn_pkg::ST_IDLE;
            txn_end_o <= 1'b1;
          end
        end
        usb_txn_pkg::ST_WAIT: begin
          if (hsk_recv_i || timeout_i) begin
            state_o   <= usb_txn_pkg::ST_IDLE;
            txn_end_o <= 1'b1;
          end
        end
        default: begin
          state_o <= usb_txn_pkg::ST_IDLE;
        end
      endcase
    end
  end

  state_legal_a: assert property (@(posedge clock) disable iff (reset)
    state_o inside {usb_txn_pkg::ST_IDLE, usb_txn_pkg::ST_RECV, usb_txn_pkg::ST_RESP,
                    usb_txn_pkg::ST_DROP, usb_txn_pkg::ST_SEND, usb_txn_pkg::ST_WAIT});

endmodule

/* src/bus_timers.sv */
`include "usb_txn_cfg.svh"

module bus_timers (
  input  logic clock,
  input  logic reset,
  input  logic ta_start_i,
  input  logic ep_start_i,
  input  logic hsk_recv_i,
  input  logic usb_busy_i,
  output logic timeout_o
);

  logic [6:0] ta_count;
  logic [7:0] ta_next;
  logic       ta_run;
  logic       ta_err;
  logic [4:0] ep_count;
  logic [5:0] ep_next;
  logic       ep_run;
  logic       ep_err;

  // Extra top bit flags the underflow
  assign ta_next = {1'b0, ta_count} - 8'd1;
  assign ep_next = {1'b0, ep_count} - 6'd1;

  // Turnaround timer, waits for the host handshake
  always_ff @(posedge clock) begin
    if (reset) begin
      ta_run <= 1'b0;
      ta_err <= 1'b0;
    end else if (ta_start_i) begin
      ta_run <= 1'b1;
      ta_err <= 1'b0;
    end else if (ta_run && (ta_next[7] || hsk_recv_i)) begin
      ta_run <= 1'b0;
      ta_err <= !hsk_recv_i;
    end else begin
      ta_err <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ta_start_i) begin
      ta_count <= `USB_TA_CYCLES;
    end else if (ta_run) begin
      ta_count <= ta_next[6:0];
    end
  end

  // Endpoint timer, stops once the encoder gets busy
  always_ff @(posedge clock) begin
    if (reset) begin
      ep_run <= 1'b0;
      ep_err <= 1'b0;
    end else if (ep_start_i) begin
      ep_run <= 1'b1;
      ep_err <= 1'b0;
    end else if (ep_run && (ep_next[5] || usb_busy_i)) begin
      ep_run <= 1'b0;
      ep_err <= !usb_busy_i;
    end else begin
      ep_err <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ep_start_i) begin
      ep_count <= `USB_EP_CYCLES;
    end else if (ep_run) begin
      ep_count <= ep_next[4:0];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      timeout_o <= 1'b0;
    end else begin
      timeout_o <= ta_err || ep_err;
    end
  end

endmodule

/* src/tx_route.sv */
module tx_route (
  input  logic                    clock,
  input  logic                    reset,
  input  usb_txn_pkg::txn_state_e state_i,
  input  usb_txn_pkg::usb_pid_e   resp_pid_i,
  input  logic                    seq_i,
  input  logic [1:0]              ep_index_i,
  input  logic                    epo_sel_i,
  input  logic                    epi_sel_i,
  input  logic                    hsk_sent_i,
  input  logic                    hsk_recv_i,
  input  logic                    txn_end_i,
  output logic                    hsk_send_o,
  output logic                    mux_enable_o,
  output logic [2:0]              mux_select_o,
  output logic [3:0]              ulpi_tuser_o,
  output logic                    ep1_finish_o,
  output logic                    ep2_finish_o
);

  usb_txn_pkg::usb_pid_e tx_pid;
  logic                  rx_seen;

  assign hsk_send_o   = state_i == usb_txn_pkg::ST_RESP;
  assign ulpi_tuser_o = tx_pid;

  always_ff @(posedge clock) begin
    if (state_i == usb_txn_pkg::ST_SEND) begin
      tx_pid <= seq_i ? usb_txn_pkg::PID_DATA1 : usb_txn_pkg::PID_DATA0;
    end else begin
      tx_pid <= resp_pid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mux_enable_o <= 1'b0;
      mux_select_o <= 3'd0;
      rx_seen      <= 1'b0;
      ep1_finish_o <= 1'b0;
      ep2_finish_o <= 1'b0;
    end else begin
      mux_enable_o <= (state_i == usb_txn_pkg::ST_SEND) || (state_i == usb_txn_pkg::ST_WAIT);
      // No endpoint selected parks the mux on an unused input
      mux_select_o <= (ep_index_i == 2'd3) ? 3'd7 : {1'b0, ep_index_i};

      // A handshake only finishes an OUT once data came in, not after a PING
      if (txn_end_i) begin
        rx_seen <= 1'b0;
      end else if (state_i == usb_txn_pkg::ST_RECV) begin
        rx_seen <= 1'b1;
      end

      ep1_finish_o <= !txn_end_i && epo_sel_i && rx_seen && hsk_sent_i;
      ep2_finish_o <= !txn_end_i && epi_sel_i && hsk_recv_i &&
                      (state_i == usb_txn_pkg::ST_WAIT);
    end
  end

  finish_excl_a: assert property (@(posedge clock) disable iff (reset)
    !(ep1_finish_o && ep2_finish_o));

endmodule

/* src/usb_txn.sv */
module usb_txn (
  input  logic       clock,
  input  logic       reset,
  input  logic       set_conf_i,
  input  logic       clr_conf_i,
  input  logic [6:0] usb_addr_i,
  input  logic       tok_recv_i,
  input  logic [6:0] tok_addr_i,
  input  logic [3:0] tok_endp_i,
  input  logic       ep1_rx_rdy_i,
  input  logic       ep2_tx_rdy_i,
  input  logic       ep0_parity_i,
  input  logic       ep1_parity_i,
  input  logic       ep2_parity_i,
  input  logic [3:0] usb_pid_i,
  input  logic       dec_actv_i,
  input  logic       usb_recv_i,
  input  logic       eop_recv_i,
  input  logic       crc_error_i,
  input  logic       hsk_recv_i,
  input  logic       hsk_sent_i,
  input  logic       usb_sent_i,
  input  logic       usb_busy_i,
  output logic       timedout_o,
  output logic       hsk_send_o,
  output logic       mux_enable_o,
  output logic [2:0] mux_select_o,
  output logic [3:0] ulpi_tuser_o,
  output logic       ep1_finish_o,
  output logic       ep2_finish_o
);

  logic                    tok_hit;
  logic                    ep_known;
  logic                    out_rdy;
  logic                    in_rdy;
  logic                    ep0_sel;
  logic                    epo_sel;
  logic                    epi_sel;
  logic [1:0]              ep_index;
  usb_txn_pkg::txn_state_e state;
  usb_txn_pkg::usb_pid_e   resp_pid;
  logic                    ta_start;
  logic                    ep_start;
  logic                    txn_end;
  logic                    seq;
  logic                    timeout;

  assign timedout_o = timeout;

  token_select u_token_select (
    .clock        (clock),
    .reset        (reset),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .usb_addr_i   (usb_addr_i),
    .tok_recv_i   (tok_recv_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .ep1_rx_rdy_i (ep1_rx_rdy_i),
    .ep2_tx_rdy_i (ep2_tx_rdy_i),
    .txn_end_i    (txn_end),
    .tok_hit_o    (tok_hit),
    .ep_known_o   (ep_known),
    .out_rdy_o    (out_rdy),
    .in_rdy_o     (in_rdy),
    .ep0_sel_o    (ep0_sel),
    .epo_sel_o    (epo_sel),
    .epi_sel_o    (epi_sel),
    .ep_index_o   (ep_index)
  );

  txn_fsm u_txn_fsm (
    .clock        (clock),
    .reset        (reset),
    .tok_hit_i    (tok_hit),
    .ep_known_i   (ep_known),
    .out_rdy_i    (out_rdy),
    .in_rdy_i     (in_rdy),
    .ep0_sel_i    (ep0_sel),
    .epo_sel_i    (epo_sel),
    .epi_sel_i    (epi_sel),
    .ep0_parity_i (ep0_parity_i),
    .ep1_parity_i (ep1_parity_i),
    .ep2_parity_i (ep2_parity_i),
    .usb_pid_i    (usb_pid_i),
    .dec_actv_i   (dec_actv_i),
    .usb_recv_i   (usb_recv_i),
    .eop_recv_i   (eop_recv_i),
    .crc_error_i  (crc_error_i),
    .hsk_recv_i   (hsk_recv_i),
    .hsk_sent_i   (hsk_sent_i),
    .usb_sent_i   (usb_sent_i),
    .timeout_i    (timeout),
    .state_o      (state),
    .resp_pid_o   (resp_pid),
    .ta_start_o   (ta_start),
    .ep_start_o   (ep_start),
    .txn_end_o    (txn_end),
    .seq_o        (seq)
  );

  bus_timers u_bus_timers (
    .clock      (clock),
    .reset      (reset),
    .ta_start_i (ta_start),
    .ep_start_i (ep_start),
    .hsk_recv_i (hsk_recv_i),
    .usb_busy_i (usb_busy_i),
    .timeout_o  (timeout)
  );

  tx_route u_tx_route (
    .clock        (clock),
    .reset        (reset),
    .state_i      (state),
    .resp_pid_i   (resp_pid),
    .seq_i        (seq),
    .ep_index_i   (ep_index),
    .epo_sel_i    (epo_sel),
    .epi_sel_i    (epi_sel),
    .hsk_sent_i   (hsk_sent_i),
    .hsk_recv_i   (hsk_recv_i),
    .txn_end_i    (txn_end),
    .hsk_send_o   (hsk_send_o),
    .mux_enable_o (mux_enable_o),
    .mux_select_o (mux_select_o),
    .ulpi_tuser_o (ulpi_tuser_o),
    .ep1_finish_o (ep1_finish_o),
    .ep2_finish_o (ep2_finish_o)
  );

endmodule

/* tb/usb_txn_tb.sv */
`include "usb_txn_cfg.svh"

module usb_txn_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [6:0] DEV_ADDR    = 7'h05;
  localparam int         CYCLE_LIMIT = 40 * (`USB_TA_CYCLES + 20);

  // Expected outcome of one transaction
  localparam int K_IGNORE = 0;
  localparam int K_HSK    = 1;
  localparam int K_DATA   = 2;
  localparam int K_SILENT = 3;
  localparam int K_DROP   = 4;

  logic       clock;
  logic       reset;
  logic       set_conf_i;
  logic       clr_conf_i;
  logic [6:0] usb_addr_i;
  logic       tok_recv_i;
  logic [6:0] tok_addr_i;
  logic [3:0] tok_endp_i;
  logic       ep1_rx_rdy_i;
  logic       ep2_tx_rdy_i;
  logic       ep0_parity_i;
  logic       ep1_parity_i;
  logic       ep2_parity_i;
  logic [3:0] usb_pid_i;
  logic       dec_actv_i;
  logic       usb_recv_i;
  logic       eop_recv_i;
  logic       crc_error_i;
  logic       hsk_recv_i;
  logic       hsk_sent_i;
  logic       usb_sent_i;
  logic       usb_busy_i;
  logic       timedout_o;
  logic       hsk_send_o;
  logic       mux_enable_o;
  logic [2:0] mux_select_o;
  logic [3:0] ulpi_tuser_o;
  logic       ep1_finish_o;
  logic       ep2_finish_o;

  integer     seed;
  logic       configured;
  int         kind_now;
  logic [3:0] pid_now;
  logic [2:0] sel_now;
  logic       sending;
  logic       hsk_prev;
  int         ep1_count;
  int         ep2_count;
  int         cycle_count;
  int         i;

  usb_txn uut (
    .clock        (clock),
    .reset        (reset),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .usb_addr_i   (usb_addr_i),
    .tok_recv_i   (tok_recv_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .ep1_rx_rdy_i (ep1_rx_rdy_i),
    .ep2_tx_rdy_i (ep2_tx_rdy_i),
    .ep0_parity_i (ep0_parity_i),
    .ep1_parity_i (ep1_parity_i),
    .ep2_parity_i (ep2_parity_i),
    .usb_pid_i    (usb_pid_i),
    .dec_actv_i   (dec_actv_i),
    .usb_recv_i   (usb_recv_i),
    .eop_recv_i   (eop_recv_i),
    .crc_error_i  (crc_error_i),
    .hsk_recv_i   (hsk_recv_i),
    .hsk_sent_i   (hsk_sent_i),
    .usb_sent_i   (usb_sent_i),
    .usb_busy_i   (usb_busy_i),
    .timedout_o   (timedout_o),
    .hsk_send_o   (hsk_send_o),
    .mux_enable_o (mux_enable_o),
    .mux_select_o (mux_select_o),
    .ulpi_tuser_o (ulpi_tuser_o),
    .ep1_finish_o (ep1_finish_o),
    .ep2_finish_o (ep2_finish_o)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, name, got, expected);
    $display("Verification failed");
    $fatal(1);
  endtask

  function automatic logic rand_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // Device response per the USB transaction rules
  function automatic void expected_response(
    input  logic [3:0] pid,
    input  logic [6:0] addr,
    input  logic [3:0] endp,
    input  logic       conf,
    input  logic       rdy,
    input  logic       par,
    input  logic       seq,
    output int         kind,
    output logic [3:0] exp_pid
  );
    logic is_ctrl;
    logic is_out;
    logic is_in;
    logic out_ok;
    is_ctrl = endp == 4'd0;
    is_out  = conf && (endp == `USB_EP_OUT_NUM);
    is_in   = conf && (endp == `USB_EP_IN_NUM);
    out_ok  = is_ctrl || (is_out && rdy);
    kind    = K_SILENT;
    exp_pid = usb_txn_pkg::PID_NAK;
    if (addr != DEV_ADDR) begin
      kind = K_IGNORE;
    end else if (pid == usb_txn_pkg::PID_SETUP) begin
      if (is_ctrl) begin
        kind    = (seq == par) ? K_HSK : K_DROP;
        exp_pid = usb_txn_pkg::PID_ACK;
      end
    end else if (pid == usb_txn_pkg::PID_OUT) begin
      if (out_ok) begin
        kind    = (seq == par) ? K_HSK : K_DROP;
        exp_pid = usb_txn_pkg::PID_ACK;
      end else if (is_out || is_in) begin
        kind = K_HSK;
      end
    end else if (pid == usb_txn_pkg::PID_IN) begin
      if (is_ctrl || (is_in && rdy)) begin
        kind    = K_DATA;
        exp_pid = par ? usb_txn_pkg::PID_DATA1 : usb_txn_pkg::PID_DATA0;
      end else if (is_out || is_in) begin
        kind = K_HSK;
      end
    end else if (pid == usb_txn_pkg::PID_PING) begin
      kind    = K_HSK;
      exp_pid = out_ok ? usb_txn_pkg::PID_ACK : usb_txn_pkg::PID_NAK;
    end
  endfunction

  // Waits at falling edges for hsk_send_o (0), mux_enable_o (1) or timedout_o
  task automatic wait_for_output(input int which, input int limit, input string what,
                                 output int waited);
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < limit) begin
      @(negedge clock);
      case (which)
        0: seen = hsk_send_o;
        1: seen = mux_enable_o;
        default: seen = timedout_o;
      endcase
      if (!seen) begin
        waited++;
      end
    end
    if (!seen) begin
      $display("Expected %s did not happen within %0d cycles at time %0t", what, limit, $time);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic send_token(input logic [3:0] pid, input logic [6:0] addr,
                            input logic [3:0] endp);
    @(posedge clock);
    tok_recv_i <= 1'b1;
    tok_addr_i <= addr;
    tok_endp_i <= endp;
    usb_pid_i  <= pid;
    @(posedge clock);
    tok_recv_i <= 1'b0;
  endtask

  // DATAx packet from the host, the decoder busy pulse stops the endpoint timer
  task automatic send_data(input logic seq);
    @(posedge clock);
    dec_actv_i <= 1'b1;
    usb_pid_i  <= seq ? usb_txn_pkg::PID_DATA1 : usb_txn_pkg::PID_DATA0;
    @(posedge clock);
    dec_actv_i <= 1'b0;
    usb_busy_i <= 1'b1;
    @(posedge clock);
    usb_busy_i <= 1'b0;
    usb_recv_i <= 1'b1;
    eop_recv_i <= 1'b1;
    @(posedge clock);
    usb_recv_i <= 1'b0;
    eop_recv_i <= 1'b0;
  endtask

  task automatic answer_handshake();
    int waited;
    wait_for_output(0, 20, "handshake request", waited);
    @(negedge clock);
    @(posedge clock);
    usb_busy_i <= 1'b1;
    @(posedge clock);
    usb_busy_i <= 1'b0;
    hsk_sent_i <= 1'b1;
    @(posedge clock);
    hsk_sent_i <= 1'b0;
    @(negedge clock);
    assert (hsk_send_o == 1'b0) else report_mismatch("hsk_send_o", hsk_send_o, 0);
  endtask

  // Encoder sends the DATAx, then the host acknowledges it
  task automatic answer_in_data();
    int waited;
    wait_for_output(1, 20, "data mux enable", waited);
    @(posedge clock);
    usb_busy_i <= 1'b1;
    @(posedge clock);
    usb_busy_i <= 1'b0;
    usb_sent_i <= 1'b1;
    sending = 1'b0;
    @(posedge clock);
    usb_sent_i <= 1'b0;
    @(posedge clock);
    hsk_recv_i <= 1'b1;
    @(posedge clock);
    hsk_recv_i <= 1'b0;
  endtask

  task automatic set_config(input logic enable);
    @(posedge clock);
    set_conf_i <= enable;
    clr_conf_i <= !enable;
    configured = enable;
    @(posedge clock);
    set_conf_i <= 1'b0;
    clr_conf_i <= 1'b0;
  endtask

  task automatic run_transaction(input logic [3:0] pid, input logic [6:0] addr,
                                 input logic [3:0] endp, input logic rdy,
                                 input logic par, input logic seq);
    int         kind;
    logic [3:0] exp_pid;
    int         ep1_start;
    int         ep2_start;
    int         exp_ep1;
    int         exp_ep2;
    int         waited;
    expected_response(pid, addr, endp, configured, rdy, par, seq, kind, exp_pid);
    exp_ep1 = (kind == K_HSK && pid == usb_txn_pkg::PID_OUT &&
               exp_pid == usb_txn_pkg::PID_ACK && endp == `USB_EP_OUT_NUM) ? 1 : 0;
    exp_ep2 = (kind == K_DATA && endp == `USB_EP_IN_NUM) ? 1 : 0;
    @(posedge clock);
    ep1_rx_rdy_i <= rdy;
    ep2_tx_rdy_i <= rdy;
    ep0_parity_i <= par;
    ep1_parity_i <= par;
    ep2_parity_i <= par;
    kind_now  = kind;
    pid_now   = exp_pid;
    sel_now   = (endp == 4'd0) ? 3'd0 : 3'd2;
    sending   = (kind == K_DATA);
    ep1_start = ep1_count;
    ep2_start = ep2_count;
    send_token(pid, addr, endp);
    if (kind == K_IGNORE) begin
      repeat (30) @(negedge clock);
    end else if (kind == K_SILENT) begin
      wait_for_output(2, `USB_TA_CYCLES + 10, "turnaround timeout", waited);
      assert (waited >= `USB_TA_CYCLES + 1 && waited <= `USB_TA_CYCLES + 3)
        else report_mismatch("timedout_o latency", waited, `USB_TA_CYCLES + 2);
    end else if (kind == K_DATA) begin
      answer_in_data();
    end else begin
      if (pid == usb_txn_pkg::PID_OUT || pid == usb_txn_pkg::PID_SETUP) begin
        send_data(seq);
      end
      if (kind == K_HSK) begin
        answer_handshake();
      end else begin
        repeat (6) @(negedge clock);
      end
    end
    repeat (3) @(negedge clock);
    assert (ep1_count - ep1_start == exp_ep1)
      else report_mismatch("ep1_finish_o pulses", ep1_count - ep1_start, exp_ep1);
    assert (ep2_count - ep2_start == exp_ep2)
      else report_mismatch("ep2_finish_o pulses", ep2_count - ep2_start, exp_ep2);
  endtask

  // Output checks against the current expectation
  always @(negedge clock) begin
    if (!reset) begin
      if (ep1_finish_o) begin
        ep1_count++;
      end
      if (ep2_finish_o) begin
        ep2_count++;
      end
      if (kind_now == K_HSK) begin
        // PID is registered, so it settles one cycle into the request
        if (hsk_send_o && hsk_prev) begin
          assert (ulpi_tuser_o == pid_now)
            else report_mismatch("ulpi_tuser_o", ulpi_tuser_o, pid_now);
        end
      end else begin
        assert (!hsk_send_o) else report_mismatch("hsk_send_o", hsk_send_o, 0);
      end
      if (sending && mux_enable_o) begin
        assert (mux_select_o == sel_now)
          else report_mismatch("mux_select_o", mux_select_o, sel_now);
        assert (ulpi_tuser_o == pid_now)
          else report_mismatch("ulpi_tuser_o", ulpi_tuser_o, pid_now);
      end
      if (kind_now != K_SILENT) begin
        assert (!timedout_o) else report_mismatch("timedout_o", timedout_o, 0);
      end
      if (kind_now == K_IGNORE) begin
        assert (!mux_enable_o) else report_mismatch("mux_enable_o", mux_enable_o, 0);
        assert (!ep1_finish_o) else report_mismatch("ep1_finish_o", ep1_finish_o, 0);
        assert (!ep2_finish_o) else report_mismatch("ep2_finish_o", ep2_finish_o, 0);
      end
      hsk_prev = hsk_send_o;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Verification failed");
    $fatal(1);
  end

  initial begin
    seed         = 32'he3b2;
    reset        = 1'b1;
    set_conf_i   = 1'b0;
    clr_conf_i   = 1'b0;
    usb_addr_i   = DEV_ADDR;
    tok_recv_i   = 1'b0;
    tok_addr_i   = 7'd0;
    tok_endp_i   = 4'd0;
    ep1_rx_rdy_i = 1'b0;
    ep2_tx_rdy_i = 1'b0;
    ep0_parity_i = 1'b0;
    ep1_parity_i = 1'b0;
    ep2_parity_i = 1'b0;
    usb_pid_i    = 4'd0;
    dec_actv_i   = 1'b0;
    usb_recv_i   = 1'b0;
    eop_recv_i   = 1'b0;
    crc_error_i  = 1'b0;
    hsk_recv_i   = 1'b0;
    hsk_sent_i   = 1'b0;
    usb_sent_i   = 1'b0;
    usb_busy_i   = 1'b0;
    configured   = 1'b0;
    kind_now     = K_IGNORE;
    pid_now      = 4'd0;
    sel_now      = 3'd0;
    sending      = 1'b0;
    hsk_prev     = 1'b0;
    ep1_count    = 0;
    ep2_count    = 0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    // Bulk IN endpoint is unknown before configuration
    run_transaction(usb_txn_pkg::PID_IN, DEV_ADDR, `USB_EP_IN_NUM, 1'b1, 1'b0, 1'b0);
    set_config(1'b1);

    run_transaction(usb_txn_pkg::PID_PING, DEV_ADDR, 4'd0, 1'b0, 1'b0, 1'b0);
    for (i = 0; i < 5; i++) begin
      run_transaction(usb_txn_pkg::PID_PING, DEV_ADDR, `USB_EP_OUT_NUM, rand_bit(),
                      1'b0, 1'b0);
    end
    for (i = 0; i < 8; i++) begin
      run_transaction(usb_txn_pkg::PID_OUT, DEV_ADDR, `USB_EP_OUT_NUM, rand_bit(),
                      rand_bit(), rand_bit());
    end
    run_transaction(usb_txn_pkg::PID_SETUP, DEV_ADDR, 4'd0, 1'b1, rand_bit(), rand_bit());
    for (i = 0; i < 8; i++) begin
      run_transaction(usb_txn_pkg::PID_IN, DEV_ADDR, `USB_EP_IN_NUM, rand_bit(),
                      rand_bit(), 1'b0);
    end

    // Another device on the bus
    run_transaction(usb_txn_pkg::PID_OUT, 7'h06, `USB_EP_OUT_NUM, 1'b1, 1'b0, 1'b0);
    run_transaction(usb_txn_pkg::PID_IN, 7'h06, `USB_EP_IN_NUM, 1'b1, 1'b0, 1'b0);

    run_transaction(usb_txn_pkg::PID_SETUP, DEV_ADDR, `USB_EP_OUT_NUM, 1'b1, 1'b0, 1'b0);

    set_config(1'b0);
    run_transaction(usb_txn_pkg::PID_IN, DEV_ADDR, `USB_EP_IN_NUM, 1'b1, 1'b1, 1'b0);

    $display("Verification passed");
    $finish;
  end

endmodule

/* usb_txn.f */
+incdir+src
src/usb_txn_pkg.sv
src/token_select.sv
src/txn_fsm.sv
src/bus_timers.sv
src/tx_route.sv
src/usb_txn.sv
tb/usb_txn_tb.sv

/* Bender.yml */
package:
  name: usb_txn

sources:
  - include_dirs:
      - src
    files:
      - src/usb_txn_pkg.sv
      - src/token_select.sv
      - src/txn_fsm.sv
      - src/bus_timers.sv
      - src/tx_route.sv
      - src/usb_txn.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/usb_txn_tb.sv
